// File: rv_alu_core.f
rv_alu_pkg.sv
instr_buffer.sv
instr_decode.sv
reg_file.sv
alu_exec.sv
result_port.sv
rv_alu_core.sv
tb_rv_alu_core.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f rv_alu_core.f \
		--top-module tb_rv_alu_core -o sim_rv_alu_core
	./obj_dir/sim_rv_alu_core | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_rv_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_alu_core;

    localparam int in_depth       = 4;
    localparam int out_credits    = 4;
    localparam int n_words        = 400;
    localparam int timeout_cycles = n_words * 8 + 200;

    logic        CLK = 1'b0;
    logic        RST;
    logic        in_valid;
    logic [31:0] in_instr;
    logic        in_credit;
    logic        res_valid;
    logic [4:0]  res_rd;
    logic [31:0] res_value;
    logic        res_illegal;
    logic        res_credit;

    logic [31:0] prog [n_words];
    logic [31:0] model_regs [32];
    int          cyc = 0;
    int          sent = 0;
    int          seen = 0;
    int          credit_pulses = 0;
    int          outstanding = 0;
    int unsigned release_q [$];

    rv_alu_core #(.in_depth(in_depth), .out_credits(out_credits)) u_dut (
        .CLK(CLK), .RST(RST),
        .in_valid(in_valid), .in_instr(in_instr), .in_credit(in_credit),
        .res_valid(res_valid), .res_rd(res_rd), .res_value(res_value),
        .res_illegal(res_illegal), .res_credit(res_credit)
    );

    always #4 CLK = ~CLK;

    always @(posedge CLK) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) begin
            $display("timeout after %0d cycles, only %0d of %0d results arrived",
                     cyc, seen, n_words);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%0t: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "protocol error");
    endtask

    // op or op-imm word, sub and sra only where legal.
    function automatic logic [31:0] alu_word(input logic [31:0] s, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = s[2:0];
        f7 = (s[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        if (s[4]) begin
            return {f7, rs2, rs1, f3, rd, 7'h33};
        end else if (f3 == 3'd1 || f3 == 3'd5) begin
            return {f7, s[9:5], rs1, f3, rd, 7'h13};
        end
        return {s[31:20], rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] illegal_word(input logic [31:0] s);
        case (s[1:0])
            2'd0:    return {s[31:7], 7'h03};                          // load opcode.
            2'd1:    return {7'h01, s[24:7], 7'h33};                   // mul encoding.
            2'd2:    return {7'h20, s[24:15], 3'd1, s[11:7], 7'h13};   // slli with funct7 alt.
            default: return {7'h20, s[24:15], 3'd4, s[11:7], 7'h33};   // xor with funct7 alt.
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] st;
        logic [31:0] r;
        logic [31:0] s;
        int          cls;
        st = 32'd20538;
        prog[0] = {7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33}; // add x3, x1, x2 on zeros.
        prog[1] = {12'h123, 5'd0, 3'd0, 5'd1, 7'h13};     // addi x1, x0, 0x123.
        prog[2] = {12'hfff, 5'd1, 3'd0, 5'd2, 7'h13};     // addi x2, x1, -1.
        prog[3] = {7'h00, 5'd2, 5'd1, 3'd0, 5'd0, 7'h33}; // add x0, x1, x2.
        prog[4] = {7'h00, 5'd0, 5'd1, 3'd6, 5'd4, 7'h33}; // or x4, x1, x0.
        prog[5] = {7'h20, 5'd1, 5'd2, 3'd0, 5'd5, 7'h33}; // sub x5, x2, x1.
        prog[6] = 32'hffff_ffff;
        prog[7] = {7'h20, 5'd4, 5'd5, 3'd5, 5'd6, 7'h33}; // sra x6, x5, x4.
        for (int i = 8; i < n_words; i++) begin
            st  = xorshift32(st);
            r   = st;
            st  = xorshift32(st);
            s   = st;
            cls = int'(r % 100);
            if (cls < 5) begin
                prog[i] = illegal_word(s);
            end else if (cls < 12) begin
                prog[i] = {s[31:12], 2'b00, r[17:15], 7'h37};
            end else if (cls < 20) begin
                prog[i] = alu_word(s, 5'd0, s[19:15], s[24:20]); // x0 destination.
            end else begin
                prog[i] = alu_word(s, {2'b00, r[10:8]}, {2'b00, r[13:11]}, {2'b00, r[16:14]});
            end
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // returns {illegal, rd, value}.
    function automatic logic [37:0] expected_result(input logic [31:0] w);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic        legal;
        logic        imm_form;
        opc      = w[6:0];
        f3       = w[14:12];
        f7       = w[31:25];
        rd       = w[11:7];
        a        = model_regs[w[19:15]];
        b        = model_regs[w[24:20]];
        legal    = 1'b0;
        imm_form = (opc == 7'h13);
        if (opc == 7'h33) begin
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        end else if (imm_form && (f3 == 3'd1 || f3 == 3'd5)) begin
            b     = {27'd0, w[24:20]};
            legal = (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'd5);
        end else if (imm_form) begin
            b     = {{20{w[31]}}, w[31:20]};
            legal = 1'b1;
        end
        case (f3)
            3'd0: v = (f7 == 7'h20 && !imm_form) ? a - b : a + b;
            3'd1: v = a << b[4:0];
            3'd2: v = {31'd0, $signed(a) < $signed(b)};
            3'd3: v = {31'd0, a < b};
            3'd4: v = a ^ b;
            3'd5: begin
                if (f7 == 7'h20) begin
                    v = $signed(a) >>> b[4:0];
                end else begin
                    v = a >> b[4:0];
                end
            end
            3'd6: v = a | b;
            default: v = a & b;
        endcase
        if (opc == 7'h37) begin
            legal = 1'b1;
            v     = {w[31:12], 12'd0};
        end
        if (!legal) begin
            rd = '0;
            v  = '0; // not compared.
        end
        return {!legal, rd, v};
    endfunction

    // ----------------------------------------
    // sender, consumer and checker
    // ----------------------------------------
    initial begin
        int          credits;
        logic [31:0] st;
        credits = in_depth;
        st      = 32'd20538 ^ 32'h0000_5a5a;
        @(negedge RST);
        forever begin
            @(posedge CLK);
            #1;
            if (in_credit) begin
                credit_pulses++;
                credits++;
            end
            if (credits > in_depth) begin
                report_failure("sender got more credits back than the input buffer holds");
            end
            st = xorshift32(st);
            if (credits > 0 && sent < n_words && st[2:0] != 3'd0) begin
                in_valid = 1'b1;
                in_instr = prog[sent];
                sent++;
                credits--;
            end else begin
                in_valid = 1'b0;
            end
        end
    end

    initial begin
        logic [37:0] exp;
        logic [31:0] st;
        int unsigned rel;
        st = 32'd20538 ^ 32'h00a5_0000;
        @(negedge RST);
        forever begin
            @(posedge CLK);
            #1;
            if (res_valid && seen >= n_words) begin
                report_failure("result arrived after the end of the program");
            end else if (res_valid) begin
                exp = expected_result(prog[seen]);
                check_equal($sformatf("result %0d illegal", seen),
                            {31'd0, res_illegal}, {31'd0, exp[37]});
                check_equal($sformatf("result %0d rd", seen),
                            {27'd0, res_rd}, {27'd0, exp[36:32]});
                if (!exp[37]) begin
                    check_equal($sformatf("result %0d value", seen), res_value, exp[31:0]);
                    if (exp[36:32] != 5'd0) begin
                        model_regs[exp[36:32]] = exp[31:0];
                    end
                end
                seen++;
                outstanding++;
                if (outstanding > out_credits) begin
                    report_failure("consumer credit was overrun, too many results outstanding");
                end
                st  = xorshift32(st);
                rel = cyc + st % 6; // free 0 to 5 cycles later.
                if (release_q.size() > 0 && rel < release_q[$]) begin
                    rel = release_q[$];
                end
                release_q.push_back(rel);
            end
            res_credit = 1'b0;
            if (release_q.size() > 0 && release_q[0] <= cyc) begin
                void'(release_q.pop_front());
                res_credit = 1'b1;
                outstanding--;
            end
        end
    end

    initial begin
        RST        = 1'b1;
        in_valid   = 1'b0;
        in_instr   = '0;
        res_credit = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        repeat (8) @(posedge CLK);
        #1;
        RST = 1'b0;
        while (seen < n_words) begin
            @(posedge CLK);
        end
        repeat (4) @(posedge CLK);
        check_equal("in_credit pulses", credit_pulses, n_words);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu_core #(
    parameter int in_depth    = 4,
    parameter int out_credits = 4
) (
    input  logic                              CLK,
    input  logic                              RST,
    input  logic                              in_valid,
    input  logic [rv_alu_pkg::xlen-1:0]       in_instr,
    output logic                              in_credit,
    output logic                              res_valid,
    output logic [rv_alu_pkg::reg_addr_w-1:0] res_rd,
    output logic [rv_alu_pkg::xlen-1:0]       res_value,
    output logic                              res_illegal,
    input  logic                              res_credit
);
    import rv_alu_pkg::*;

    logic                  buf_valid;
    logic [xlen-1:0]       buf_instr;
    logic                  buf_pop;
    logic                  issue;
    logic                  issue_ok;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;

    // issue stage.
    logic                  ex_valid;
    alu_op_e               ex_op;
    logic                  ex_use_imm;
    logic [xlen-1:0]       ex_imm;
    logic [reg_addr_w-1:0] ex_rd;
    logic [reg_addr_w-1:0] ex_rs1;
    logic [reg_addr_w-1:0] ex_rs2;
    logic                  ex_illegal;

    // write-back stage.
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_value;
    logic                  wb_illegal;
    logic                  wr_valid;
    logic [reg_addr_w-1:0] wr_addr;
    logic [xlen-1:0]       wr_data;

    instr_buffer #(.in_depth(in_depth)) u_buffer (
        .CLK(CLK), .RST(RST),
        .in_valid(in_valid), .in_instr(in_instr), .buf_pop(buf_pop),
        .buf_valid(buf_valid), .buf_instr(buf_instr), .in_credit(in_credit)
    );

    instr_decode u_decode (
        .CLK(CLK), .RST(RST),
        .buf_valid(buf_valid), .buf_instr(buf_instr), .issue_ok(issue_ok),
        .buf_pop(buf_pop), .issue(issue), .rs1(rs1), .rs2(rs2),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_use_imm(ex_use_imm), .ex_imm(ex_imm),
        .ex_rd(ex_rd), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_illegal(ex_illegal)
    );

    reg_file u_regs (
        .CLK(CLK), .RST(RST),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    alu_exec u_exec (
        .CLK(CLK), .RST(RST),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_use_imm(ex_use_imm), .ex_imm(ex_imm),
        .ex_rd(ex_rd), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_illegal(ex_illegal),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_value(wb_value), .wb_illegal(wb_illegal)
    );

    result_port #(.out_credits(out_credits)) u_result (
        .CLK(CLK), .RST(RST),
        .issue(issue), .issue_ok(issue_ok),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_value(wb_value), .wb_illegal(wb_illegal),
        .res_credit(res_credit),
        .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data),
        .res_valid(res_valid), .res_rd(res_rd), .res_value(res_value),
        .res_illegal(res_illegal)
    );

endmodule

`default_nettype wire

// File: result_port.sv
`timescale 1ns/1ps
`default_nettype none

module result_port #(
    parameter int out_credits = 4
) (
    input  logic                              CLK,
    input  logic                              RST,
    input  logic                              issue,
    input  logic                              wb_valid,
    input  logic [rv_alu_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [rv_alu_pkg::xlen-1:0]       wb_value,
    input  logic                              wb_illegal,
    input  logic                              res_credit,
    output logic                              issue_ok,
    output logic                              wr_valid,
    output logic [rv_alu_pkg::reg_addr_w-1:0] wr_addr,
    output logic [rv_alu_pkg::xlen-1:0]       wr_data,
    output logic                              res_valid,
    output logic [rv_alu_pkg::reg_addr_w-1:0] res_rd,
    output logic [rv_alu_pkg::xlen-1:0]       res_value,
    output logic                              res_illegal
);
    localparam int cnt_w = $clog2(out_credits + 1);

    // free consumer slots, already net of results in flight.
    logic [cnt_w-1:0] credits;

    always_ff @(posedge CLK) begin
        if (RST) begin
            credits <= cnt_w'(out_credits);
        end else if (issue && !res_credit) begin
            credits <= credits - 1'b1;
        end else if (!issue && res_credit) begin
            credits <= credits + 1'b1;
        end
    end

    assign issue_ok = (credits != '0);

    assign wr_valid = wb_valid && !wb_illegal;
    assign wr_addr  = wb_rd;
    assign wr_data  = wb_value;

    assign res_valid   = wb_valid;
    assign res_rd      = wb_rd;
    assign res_value   = wb_value;
    assign res_illegal = wb_illegal;

    a_credit_max: assert property (@(posedge CLK) disable iff (RST)
        credits <= cnt_w'(out_credits))
        else $error("consumer credit overrun, counter above out_credits");

endmodule

`default_nettype wire

// File: alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  logic                              CLK,
    input  logic                              RST,
    input  logic                              ex_valid,
    input  rv_alu_pkg::alu_op_e               ex_op,
    input  logic                              ex_use_imm,
    input  logic [rv_alu_pkg::xlen-1:0]       ex_imm,
    input  logic [rv_alu_pkg::reg_addr_w-1:0] ex_rd,
    input  logic [rv_alu_pkg::reg_addr_w-1:0] ex_rs1,
    input  logic [rv_alu_pkg::reg_addr_w-1:0] ex_rs2,
    input  logic                              ex_illegal,
    input  logic [rv_alu_pkg::xlen-1:0]       rs1_data,
    input  logic [rv_alu_pkg::xlen-1:0]       rs2_data,
    output logic                              wb_valid,
    output logic [rv_alu_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_alu_pkg::xlen-1:0]       wb_value,
    output logic                              wb_illegal
);
    import rv_alu_pkg::*;

    logic            wb_live;
    logic            fwd_a;
    logic            fwd_b;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b_reg;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] result;

    // ----------------------------------------
    // forwarding from the write-back stage
    // ----------------------------------------
    assign wb_live  = wb_valid && !wb_illegal && (wb_rd != '0);
    assign fwd_a    = wb_live && (wb_rd == ex_rs1);
    assign fwd_b    = wb_live && (wb_rd == ex_rs2);
    assign op_a     = fwd_a ? wb_value : rs1_data;
    assign op_b_reg = fwd_b ? wb_value : rs2_data;
    assign op_b     = ex_use_imm ? ex_imm : op_b_reg;
    assign shamt    = op_b[4:0];

    always_comb begin
        case (ex_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_sll:    result = op_a << shamt;
            alu_slt:    result = {{(xlen - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   result = {{(xlen - 1){1'b0}}, op_a < op_b};
            alu_xor:    result = op_a ^ op_b;
            alu_srl:    result = op_a >> shamt;
            alu_sra:    result = $signed(op_a) >>> shamt;
            alu_or:     result = op_a | op_b;
            alu_and:    result = op_a & op_b;
            alu_pass_b: result = op_b;
            default:    result = '0;
        endcase
    end

    // ----------------------------------------
    // write-back register
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (RST) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge CLK) begin
        wb_rd      <= ex_rd;
        wb_value   <= result;
        wb_illegal <= ex_illegal;
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                              CLK,
    input  logic                              RST,
    input  logic [rv_alu_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_alu_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_alu_pkg::xlen-1:0]       rs1_data,
    output logic [rv_alu_pkg::xlen-1:0]       rs2_data,
    input  logic                              wr_valid,
    input  logic [rv_alu_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [rv_alu_pkg::xlen-1:0]       wr_data
);
    import rv_alu_pkg::*;

    logic [reg_addr_w-1:0] rs1_q;
    logic [reg_addr_w-1:0] rs2_q;
    logic [xlen-1:0]       regs [2**reg_addr_w];

    // read addresses captured, data read straight from the array.
    always_ff @(posedge CLK) begin
        rs1_q <= rs1;
        rs2_q <= rs2;
    end

    assign rs1_data = regs[rs1_q];
    assign rs2_data = regs[rs2_q];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid && wr_addr != '0) begin // x0 stays zero.
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  logic                              CLK,
    input  logic                              RST,
    input  logic                              buf_valid,
    input  logic [rv_alu_pkg::xlen-1:0]       buf_instr,
    input  logic                              issue_ok,
    output logic                              buf_pop,
    output logic                              issue,
    output logic [rv_alu_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_alu_pkg::reg_addr_w-1:0] rs2,
    output logic                              ex_valid,
    output rv_alu_pkg::alu_op_e               ex_op,
    output logic                              ex_use_imm,
    output logic [rv_alu_pkg::xlen-1:0]       ex_imm,
    output logic [rv_alu_pkg::reg_addr_w-1:0] ex_rd,
    output logic [rv_alu_pkg::reg_addr_w-1:0] ex_rs1,
    output logic [rv_alu_pkg::reg_addr_w-1:0] ex_rs2,
    output logic                              ex_illegal
);
    import rv_alu_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            f3;
    logic [6:0]            f7;
    logic [reg_addr_w-1:0] f_rd;
    logic [reg_addr_w-1:0] f_rs1;
    logic [reg_addr_w-1:0] f_rs2;
    logic                  alt;

    alu_op_e               d_op;
    logic                  d_use_imm;
    logic [xlen-1:0]       d_imm;
    logic                  d_legal;

    assign opcode = buf_instr[6:0];
    assign f_rd   = buf_instr[11:7];
    assign f3     = buf_instr[14:12];
    assign f_rs1  = buf_instr[19:15];
    assign f_rs2  = buf_instr[24:20];
    assign f7     = buf_instr[31:25];
    assign alt    = (f7 == f7_alt);

    assign buf_pop = buf_valid && issue_ok;
    assign issue   = buf_pop; // output credit reserved here.

    // ----------------------------------------
    // decode
    // ----------------------------------------
    always_comb begin
        d_use_imm = 1'b0;
        d_imm     = '0;
        d_legal   = 1'b0;
        rs1       = f_rs1;
        rs2       = f_rs2;
        case (f3)
            f3_add_sub: d_op = alt ? alu_sub : alu_add;
            f3_sll:     d_op = alu_sll;
            f3_slt:     d_op = alu_slt;
            f3_sltu:    d_op = alu_sltu;
            f3_xor:     d_op = alu_xor;
            f3_srl_sra: d_op = alt ? alu_sra : alu_srl;
            f3_or:      d_op = alu_or;
            f3_and:     d_op = alu_and;
        endcase
        case (opcode)
            opc_op: begin
                d_legal = (f7 == f7_base) || (alt && (f3 == f3_add_sub || f3 == f3_srl_sra));
            end
            opc_op_imm: begin
                d_use_imm = 1'b1;
                rs2       = '0;
                if (f3 == f3_sll || f3 == f3_srl_sra) begin
                    d_imm   = {{(xlen - reg_addr_w){1'b0}}, f_rs2}; // shamt only.
                    d_legal = (f7 == f7_base) || (alt && f3 == f3_srl_sra);
                end else begin
                    d_imm   = {{(xlen - 12){buf_instr[31]}}, buf_instr[31:20]};
                    d_legal = 1'b1;
                    if (f3 == f3_add_sub) begin
                        d_op = alu_add; // no subi.
                    end
                end
            end
            opc_lui: begin
                d_op      = alu_pass_b;
                d_use_imm = 1'b1;
                d_imm     = {buf_instr[31:12], 12'b0};
                d_legal   = 1'b1;
                rs1       = '0;
                rs2       = '0;
            end
            default: ;
        endcase
    end

    // ----------------------------------------
    // issue registers
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (RST) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= buf_pop;
        end
    end

    always_ff @(posedge CLK) begin
        ex_op      <= d_op;
        ex_use_imm <= d_use_imm;
        ex_imm     <= d_imm;
        ex_rd      <= d_legal ? f_rd : '0; // illegal never writes.
        ex_rs1     <= rs1;
        ex_rs2     <= rs2;
        ex_illegal <= !d_legal;
    end

    // a waiting word stays at the buffer head until popped.
    a_head_hold: assert property (@(posedge CLK) disable iff (RST)
        (buf_valid && !buf_pop) |=> (buf_valid && $stable(buf_instr)))
        else $error("instr_decode saw the buffer head change before its pop");

endmodule

`default_nettype wire

// File: instr_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module instr_buffer #(
    parameter int in_depth = 4
) (
    input  logic                      CLK,
    input  logic                      RST,
    input  logic                      in_valid,
    input  logic [rv_alu_pkg::xlen-1:0] in_instr,
    input  logic                      buf_pop,
    output logic                      buf_valid,
    output logic [rv_alu_pkg::xlen-1:0] buf_instr,
    output logic                      in_credit
);
    import rv_alu_pkg::*;

    localparam int ptr_w = (in_depth > 1) ? $clog2(in_depth) : 1;
    localparam int cnt_w = $clog2(in_depth + 1);

    logic [xlen-1:0]  mem [in_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_pop;

    assign do_pop    = buf_pop && buf_valid;
    assign buf_valid = (count != '0);
    assign buf_instr = mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_instr;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            in_credit <= do_pop; // one credit back per pop.
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (in_valid && !do_pop) begin
                count <= count + 1'b1;
            end else if (!in_valid && do_pop) begin
                count <= count - 1'b1;
            end
        end
    end

    // sender must hold a credit for every word.
    a_no_overflow: assert property (@(posedge CLK) disable iff (RST)
        in_valid |-> (count != cnt_w'(in_depth)))
        else $error("instr_buffer written while full, credit violation");

endmodule

`default_nettype wire

// File: rv_alu_pkg.sv
`default_nettype none

package rv_alu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // ----------------------------------------
    // major opcodes
    // ----------------------------------------
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    // funct3 values shared by OP and OP-IMM.
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra.

    // ----------------------------------------
    // alu operations
    // ----------------------------------------
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b // lui.
    } alu_op_e;

endpackage

`default_nettype wire
